// File: compile.f
design/nes_map_pkg.sv
design/nes_bus_pkg.sv
design/byte_ram.sv
design/cpu_axil_port.sv
design/cpu_bus_fabric.sv
design/controller_port.sv
design/ppu_bus_fabric.sv
design/ppu_reg_port.sv
design/nes_mem_subsys.sv
dv/nes_mem_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the NES memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module nes_mem_tb \
	-f compile.f -o nes_mem_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/nes_mem_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
	exit 0
fi
exit 1

// File: dv/nes_mem_tb.sv
//======================================
// NES memory subsystem testbench
// Random AXI traffic against a byte-level model
//======================================
`timescale 1ns/1ps

module nes_mem_tb
	import nes_map_pkg::*;
	import nes_bus_pkg::*;
();

	// Operation counts per phase
	localparam int unsigned n_prg_rd = 300;
	localparam int unsigned n_prg_wr = 50;
	localparam int unsigned n_ram_ops = 600;
	localparam int unsigned n_unmapped = 60;
	localparam int unsigned n_axi = 150;
	localparam int unsigned n_ppu = 1500;
	localparam int unsigned n_joy = 6;
	// Cycles allowed for one handshake
	localparam int unsigned hs_limit = 64;
	localparam longint unsigned total_ops = prg_words + chr_words + n_prg_rd + 2 * n_prg_wr +
		sysram_words + n_ram_ops + n_unmapped + 4 * n_axi + vram_words + pal_words + 7 +
		3 * n_ppu + 14 * n_joy;
	// 40 cycles of 20 ns per operation, twice over
	localparam longint unsigned wd_ns = total_ops * 40 * 20 * 2;

	logic       clk;
	logic       rst_n;
	axil_req_t  axil_req;
	axil_rsp_t  axil_rsp;
	rom_load_t  rom_load;
	logic [7:0] keycode;
	logic       mirror_v;

	int    value_errors;
	int    hs_errors;
	string test_name;

	//======================================
	// Reference model state
	//======================================
	logic [7:0]  sys_m [sysram_words];
	logic [7:0]  prg_m [prg_words];
	logic [7:0]  chr_m [chr_words];
	logic [7:0]  vram_m [vram_words];
	logic [7:0]  pal_m [pal_words];
	logic [13:0] v_m;
	logic        tog_m;
	logic [7:0]  ctrl_m;
	logic [7:0]  buf_m;
	logic        strobe_m;
	logic [7:0]  shift_m;

	nes_mem_subsys dut_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.axil_req        (axil_req),
		.axil_rsp        (axil_rsp),
		.rom_load        (rom_load),
		.keycode         (keycode),
		.mirror_vertical (mirror_v)
	);

	// 20 ns clock
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Run limit
	initial begin
		#(wd_ns);
		$display("Watchdog expired after %0d ns, the test did not finish", wd_ns);
		$display("*** TEST FAILED ***");
		$finish;
	end

	function automatic logic coin();
		return $urandom_range(0, 1) != 0;
	endfunction

	// Vertical keeps A10, horizontal takes A11 as bit 10
	function automatic logic [10:0] vram_index(input logic [13:0] a, input logic vert);
		logic [10:0] idx;
		idx = a[10:0];
		if (!vert) idx[10] = a[11];
		return idx;
	endfunction

	// $3F10/$14/$18/$1C fold onto $3F00/$04/$08/$0C
	function automatic logic [4:0] pal_index(input logic [13:0] a);
		logic [4:0] idx;
		idx = a[4:0];
		if (a[1:0] == 2'b00) idx[4] = 1'b0;
		return idx;
	endfunction

	function automatic logic [7:0] ppu_byte(input logic [13:0] a);
		if (a < 14'h2000) return chr_m[a[12:0]];
		if (a < pal_base) return vram_m[vram_index(a, mirror_v)];
		return pal_m[pal_index(a)];
	endfunction

	// Random mirror within the register window
	function automatic logic [15:0] reg_at(input logic [2:0] off);
		return 16'h2000 | {3'b000, 10'($urandom_range(0, 1023)), off};
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			value_errors++;
			$display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	//======================================
	// AXI4-Lite host, called at edge + 1 ns
	//======================================
	task automatic axi_write(input logic [15:0] addr, input logic [7:0] data,
		input logic [3:0] strb);
		int          cyc;
		logic        accepted;
		logic        answered;
		logic [31:0] rnd;
		accepted = 1'b0;
		answered = 1'b0;
		cyc = 0;
		rnd = $urandom();
		// Upper lanes carry junk
		axil_req.awvalid = 1'b1;
		axil_req.awaddr = addr;
		axil_req.wvalid = 1'b1;
		axil_req.wdata = {rnd[31:8], data};
		axil_req.wstrb = strb;
		while (!accepted && cyc < hs_limit) begin
			@(negedge clk);
			accepted = axil_rsp.awready && axil_rsp.wready;
			@(posedge clk);
			#1;
			cyc++;
		end
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		cyc = 0;
		// Random back-pressure on B
		while (accepted && !answered && cyc < hs_limit) begin
			axil_req.bready = coin();
			@(negedge clk);
			if (axil_rsp.bvalid && axil_req.bready) begin
				answered = 1'b1;
				check_value($sformatf("bresp %h", addr), 32'h0, {30'h0, axil_rsp.bresp});
			end
			@(posedge clk);
			#1;
			cyc++;
		end
		axil_req.bready = 1'b0;
		assert (accepted) else begin
			hs_errors++;
			$display("%s: AXI write to %h was never accepted", test_name, addr);
		end
		assert (!accepted || answered) else begin
			hs_errors++;
			$display("%s: AXI write to %h got no write response", test_name, addr);
		end
	endtask

	task automatic axi_read(input logic [15:0] addr, output logic [31:0] data);
		int   cyc;
		logic accepted;
		logic answered;
		accepted = 1'b0;
		answered = 1'b0;
		cyc = 0;
		data = 32'hxxxx_xxxx;
		axil_req.arvalid = 1'b1;
		axil_req.araddr = addr;
		while (!accepted && cyc < hs_limit) begin
			@(negedge clk);
			accepted = axil_rsp.arready;
			@(posedge clk);
			#1;
			cyc++;
		end
		axil_req.arvalid = 1'b0;
		cyc = 0;
		// Random back-pressure on R
		while (accepted && !answered && cyc < hs_limit) begin
			axil_req.rready = coin();
			@(negedge clk);
			if (axil_rsp.rvalid && axil_req.rready) begin
				answered = 1'b1;
				data = axil_rsp.rdata;
				check_value($sformatf("rresp %h", addr), 32'h0, {30'h0, axil_rsp.rresp});
			end
			@(posedge clk);
			#1;
			cyc++;
		end
		axil_req.rready = 1'b0;
		assert (accepted && answered) else begin
			hs_errors++;
			$display("%s: AXI read of %h did not complete", test_name, addr);
		end
	endtask

	// One byte per cycle through the programmer port
	task automatic load_rom(input rom_tgt_e tgt, input logic [15:0] addr, input logic [7:0] data);
		rom_load.valid = 1'b1;
		rom_load.target = tgt;
		rom_load.addr = addr;
		rom_load.data = data;
		@(posedge clk);
		#1;
		rom_load.valid = 1'b0;
	endtask

	//======================================
	// CPU accesses with model update
	//======================================
	task automatic advance_vaddr();
		v_m = v_m + (ctrl_m[2] ? 14'd32 : 14'd1);
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		if (addr < ppu_reg_base) begin
			sys_m[addr[10:0]] = data;
		end else if (addr <= ppu_reg_end) begin
			case (addr[2:0])
				reg_ctrl: ctrl_m = data;
				reg_addr: begin
					if (!tog_m) v_m[13:8] = data[5:0];
					else v_m[7:0] = data;
					tog_m = !tog_m;
				end
				reg_data: begin
					// CHR-ROM ignores PPU writes
					if (v_m >= pal_base) pal_m[pal_index(v_m)] = data;
					else if (v_m >= 14'h2000) vram_m[vram_index(v_m, mirror_v)] = data;
					advance_vaddr();
				end
				default: ;
			endcase
		end else if (addr == joy_addr) begin
			strobe_m = data[0];
			if (data[0]) shift_m = keycode;
		end
		axi_write(addr, data, {3'($urandom_range(0, 7)), 1'b1});
	endtask

	task automatic cpu_read_check(input logic [15:0] addr);
		logic [7:0]  exp;
		logic [31:0] act;
		if (addr < ppu_reg_base) begin
			exp = sys_m[addr[10:0]];
		end else if (addr <= ppu_reg_end) begin
			case (addr[2:0])
				reg_status: begin
					exp = 8'h00;
					tog_m = 1'b0;
				end
				reg_data: begin
					// Palette bypasses the read buffer
					if (v_m >= pal_base) begin
						exp = ppu_byte(v_m);
						buf_m = exp;
					end else begin
						exp = buf_m;
						buf_m = ppu_byte(v_m);
					end
					advance_vaddr();
				end
				default: exp = open_bus;
			endcase
		end else if (addr == joy_addr) begin
			exp = {7'b0, shift_m[0]};
			if (!strobe_m) shift_m = {1'b1, shift_m[7:1]};
		end else if (addr >= prg_base) begin
			exp = prg_m[addr[14:0]];
		end else begin
			exp = open_bus;
		end
		axi_read(addr, act);
		check_value($sformatf("read %h", addr), {24'h0, exp}, act);
	endtask

	//======================================
	// Test phases
	//======================================
	task automatic prg_test();
		logic [15:0] a;
		test_name = "rom load";
		for (int i = 0; i < prg_words; i++) begin
			prg_m[i] = 8'($urandom());
			load_rom(tgt_prg, 16'(i), prg_m[i]);
		end
		for (int i = 0; i < chr_words; i++) begin
			chr_m[i] = 8'($urandom());
			load_rom(tgt_chr, 16'(i), chr_m[i]);
		end
		test_name = "prg";
		for (int i = 0; i < n_prg_rd; i++) begin
			cpu_read_check(prg_base | 16'($urandom_range(0, 32767)));
		end
		// ROM must ignore CPU writes
		for (int i = 0; i < n_prg_wr; i++) begin
			a = prg_base | 16'($urandom_range(0, 32767));
			cpu_write(a, 8'($urandom()));
			cpu_read_check(a);
		end
	endtask

	task automatic ram_test();
		logic [15:0] a;
		test_name = "sysram";
		// Fill through random mirrors
		for (int i = 0; i < sysram_words; i++) begin
			cpu_write(16'(i + 2048 * $urandom_range(0, 3)), 8'($urandom()));
		end
		for (int i = 0; i < n_ram_ops; i++) begin
			a = 16'($urandom_range(0, 16'h1FFF));
			if (coin()) cpu_write(a, 8'($urandom()));
			else cpu_read_check(a);
		end
		test_name = "unmapped";
		for (int i = 0; i < n_unmapped; i++) begin
			a = 16'($urandom_range(16'h4000, 16'h7FFF));
			if (a == joy_addr) a = 16'h4017;
			cpu_read_check(a);
		end
	endtask

	task automatic axi_test();
		logic [15:0] a;
		logic [7:0]  d;
		test_name = "axi";
		for (int i = 0; i < n_axi; i++) begin
			a = 16'($urandom_range(0, 16'h1FFF));
			d = 8'($urandom());
			cpu_write(a, d);
			cpu_read_check(a);
			// Lane 0 strobe clear, memory keeps d
			axi_write(a, ~d, {3'($urandom_range(0, 7)), 1'b0});
			cpu_read_check(a);
		end
	endtask

	task automatic ppu_test();
		logic [13:0] va;
		logic [2:0]  wo_off;
		test_name = "ppu init";
		mirror_v = 1'b1;
		cpu_write(16'h2000, 8'h00);
		cpu_write(16'h2006, 8'h20);
		cpu_write(16'h2006, 8'h00);
		// $2000-$27FF covers all of VRAM when vertical
		for (int i = 0; i < vram_words; i++) cpu_write(16'h2007, 8'($urandom()));
		cpu_write(16'h2006, 8'h3F);
		cpu_write(16'h2006, 8'h00);
		for (int i = 0; i < pal_words; i++) cpu_write(16'h2007, 8'($urandom()));
		test_name = "ppu";
		for (int i = 0; i < n_ppu; i++) begin
			case ($urandom_range(0, 9))
				0: cpu_write(reg_at(reg_ctrl), 8'($urandom()));
				1: begin
					// Reset the toggle, then a full address
					va = 14'($urandom());
					if (coin()) va[13:8] = 6'h3F;
					cpu_read_check(reg_at(reg_status));
					cpu_write(reg_at(reg_addr), {2'($urandom_range(0, 3)), va[13:8]});
					cpu_write(reg_at(reg_addr), va[7:0]);
				end
				2: cpu_write(reg_at(reg_addr), 8'($urandom()));
				3: cpu_read_check(reg_at(reg_status));
				4, 5: cpu_write(reg_at(reg_data), 8'($urandom()));
				6, 7: cpu_read_check(reg_at(reg_data));
				8: mirror_v = coin();
				default: begin
					// Write-only offsets read as open bus
					wo_off = 3'($urandom_range(0, 5));
					if (wo_off >= 3'd2) wo_off = wo_off + 3'd1;
					cpu_read_check(reg_at(wo_off));
				end
			endcase
		end
	endtask

	task automatic joy_test();
		test_name = "joypad";
		for (int r = 0; r < n_joy; r++) begin
			keycode = 8'($urandom());
			cpu_write(joy_addr, {7'($urandom()), 1'b1});
			cpu_write(joy_addr, {7'($urandom()), 1'b0});
			// Eight key bits, then ones
			repeat (12) cpu_read_check(joy_addr);
		end
	endtask

	//======================================
	// Main sequence
	//======================================
	initial begin
		value_errors = 0;
		hs_errors = 0;
		test_name = "reset";
		void'($urandom(32'h5d41_2628));
		axil_req = '0;
		rom_load = '0;
		keycode = 8'h00;
		mirror_v = 1'b1;
		rst_n = 1'b0;
		v_m = 14'h0000;
		tog_m = 1'b0;
		ctrl_m = 8'h00;
		buf_m = 8'h00;
		strobe_m = 1'b0;
		shift_m = 8'h00;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;
		prg_test();
		ram_test();
		axi_test();
		ppu_test();
		joy_test();
		$display("Error counts: %0d value, %0d handshake", value_errors, hs_errors);
		if (value_errors == 0 && hs_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: design/nes_mem_subsys.sv
//======================================
// NES memory subsystem
// AXI host port, CPU and PPU fabrics, joypad
//======================================
`timescale 1ns/1ps

module nes_mem_subsys
	import nes_bus_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  axil_req_t  axil_req,
	output axil_rsp_t  axil_rsp,
	input  rom_load_t  rom_load,
	input  logic [7:0] keycode,
	input  logic       mirror_vertical
);

	// CPU bus
	cpu_req_t   cpu_req;
	logic [7:0] cpu_rdata;
	// Register window and joypad branches
	cpu_req_t   reg_req;
	logic [7:0] reg_rdata;
	cpu_req_t   joy_req;
	logic [7:0] joy_rdata;
	// PPU bus
	ppu_req_t   ppu_req;
	logic [7:0] ppu_rdata;

	//======================================
	// CPU side
	//======================================
	cpu_axil_port axil_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.axil_req  (axil_req),
		.axil_rsp  (axil_rsp),
		.cpu_req   (cpu_req),
		.cpu_rdata (cpu_rdata)
	);

	cpu_bus_fabric cpu_fab_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_req   (cpu_req),
		.cpu_rdata (cpu_rdata),
		.rom_load  (rom_load),
		.reg_req   (reg_req),
		.reg_rdata (reg_rdata),
		.joy_req   (joy_req),
		.joy_rdata (joy_rdata)
	);

	controller_port joy_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.joy_req   (joy_req),
		.keycode   (keycode),
		.joy_rdata (joy_rdata)
	);

	//======================================
	// Bridge and PPU side
	//======================================
	ppu_reg_port reg_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.reg_req   (reg_req),
		.reg_rdata (reg_rdata),
		.ppu_req   (ppu_req),
		.ppu_rdata (ppu_rdata)
	);

	ppu_bus_fabric ppu_fab_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.ppu_req         (ppu_req),
		.ppu_rdata       (ppu_rdata),
		.rom_load        (rom_load),
		.mirror_vertical (mirror_vertical)
	);

endmodule

// File: design/ppu_reg_port.sv
//======================================
// PPU register port
// PPUCTRL, PPUADDR and PPUDATA between the buses
//======================================
`timescale 1ns/1ps

module ppu_reg_port
	import nes_map_pkg::*;
	import nes_bus_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  cpu_req_t   reg_req,
	output logic [7:0] reg_rdata,
	output ppu_req_t   ppu_req,
	input  logic [7:0] ppu_rdata
);

	// What the CPU sees one cycle after a read
	typedef enum logic [1:0] {
		rs_open,
		rs_zero,
		rs_buf,
		rs_ppu
	} rsel_e;

	rsel_e       rsel_q;
	logic [7:0]  ppu_ctrl;
	logic [13:0] vaddr;
	logic        toggle;
	logic [7:0]  rbuf;
	logic        refill_q;
	logic [2:0]  off;
	logic        data_acc;
	logic [13:0] vinc;

	// 8-byte mirror of the register window
	assign off = reg_req.addr[2:0];
	assign data_acc = (reg_req.rd || reg_req.wr) && (off == reg_data);
	// PPUCTRL bit 2 picks a row step
	assign vinc = ppu_ctrl[2] ? 14'd32 : 14'd1;

	//======================================
	// PPU bus side
	//======================================
	always_comb begin
		ppu_req.rd = reg_req.rd && (off == reg_data);
		ppu_req.wr = reg_req.wr && (off == reg_data);
		ppu_req.addr = vaddr;
		ppu_req.wdata = reg_req.wdata;
	end

	//======================================
	// Register state
	//======================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ppu_ctrl <= 8'h00;
			vaddr <= 14'h0000;
			toggle <= 1'b0;
			rbuf <= 8'h00;
			refill_q <= 1'b0;
			rsel_q <= rs_open;
		end else begin
			// Buffer takes the PPU byte a cycle after the read
			refill_q <= ppu_req.rd;
			if (refill_q) begin
				rbuf <= ppu_rdata;
			end
			if (reg_req.wr) begin
				case (off)
					reg_ctrl: ppu_ctrl <= reg_req.wdata;
					reg_addr: begin
						// High 6 bits first, then low byte
						if (!toggle) vaddr[13:8] <= reg_req.wdata[5:0];
						else vaddr[7:0] <= reg_req.wdata;
						toggle <= !toggle;
					end
					default: ;
				endcase
			end
			if (reg_req.rd) begin
				case (off)
					reg_status: begin
						// Status read resets the write latch
						rsel_q <= rs_zero;
						toggle <= 1'b0;
					end
					// Palette bypasses the buffer
					reg_data: rsel_q <= (vaddr >= pal_base) ? rs_ppu : rs_buf;
					default:  rsel_q <= rs_open;
				endcase
			end
			// Post-access step, wraps in 14 bits
			if (data_acc) begin
				vaddr <= vaddr + vinc;
			end
		end
	end

	// Old buffer is still in place during the return cycle
	always_comb begin
		case (rsel_q)
			rs_zero: reg_rdata = 8'h00;
			rs_buf:  reg_rdata = rbuf;
			rs_ppu:  reg_rdata = ppu_rdata;
			default: reg_rdata = open_bus;
		endcase
	end

	// One PPU access direction per cycle
	a_ppu_rw: assert property (@(posedge clk) disable iff (!rst_n)
		!(ppu_req.rd && ppu_req.wr));

endmodule

// File: design/ppu_bus_fabric.sv
//======================================
// PPU bus fabric
// CHR-ROM, mirrored nametables and palette RAM
//======================================
`timescale 1ns/1ps

module ppu_bus_fabric
	import nes_map_pkg::*;
	import nes_bus_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  ppu_req_t   ppu_req,
	output logic [7:0] ppu_rdata,
	input  rom_load_t  rom_load,
	input  logic       mirror_vertical
);

	typedef enum logic [1:0] {
		src_chr,
		src_vram,
		src_pal
	} src_e;

	src_e               src_q;
	logic               chr_sel;
	logic               vram_sel;
	logic               pal_sel;
	logic               chr_load;
	logic [chr_aw-1:0]  chr_addr;
	logic [vram_aw-1:0] vram_addr;
	logic [pal_aw-1:0]  pal_addr;
	logic [7:0]         chr_q;
	logic [7:0]         vram_q;
	logic [7:0]         pal_q;

	//======================================
	// Address decode
	//======================================
	// Pattern tables fill the low 8 KB
	assign chr_sel = ppu_req.addr < chr_words;
	assign pal_sel = ppu_req.addr >= pal_base;
	// Nametables and their $3000 mirror
	assign vram_sel = !chr_sel && !pal_sel;

	// Vertical keeps A10, horizontal moves A11 down
	assign vram_addr = {mirror_vertical ? ppu_req.addr[10] : ppu_req.addr[11],
	                    ppu_req.addr[9:0]};

	// Sprite backdrop entries alias the BG ones
	assign pal_addr = {ppu_req.addr[4] && (ppu_req.addr[1:0] != 2'b00), ppu_req.addr[3:0]};

	// Loader takes the CHR port
	assign chr_load = rom_load.valid && (rom_load.target == tgt_chr);
	assign chr_addr = chr_load ? rom_load.addr[chr_aw-1:0] : ppu_req.addr[chr_aw-1:0];

	//======================================
	// Memories
	//======================================
	// PPU writes to CHR-ROM are ignored
	byte_ram #(.DEPTH(chr_words)) chr_rom_i (
		.clk   (clk),
		.we    (chr_load),
		.re    (ppu_req.rd && chr_sel),
		.addr  (chr_addr),
		.wdata (rom_load.data),
		.rdata (chr_q)
	);

	byte_ram #(.DEPTH(vram_words)) vram_i (
		.clk   (clk),
		.we    (ppu_req.wr && vram_sel),
		.re    (ppu_req.rd && vram_sel),
		.addr  (vram_addr),
		.wdata (ppu_req.wdata),
		.rdata (vram_q)
	);

	byte_ram #(.DEPTH(pal_words)) pal_i (
		.clk   (clk),
		.we    (ppu_req.wr && pal_sel),
		.re    (ppu_req.rd && pal_sel),
		.addr  (pal_addr),
		.wdata (ppu_req.wdata),
		.rdata (pal_q)
	);

	// Source of the last read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			src_q <= src_chr;
		end else if (ppu_req.rd) begin
			if (chr_sel) src_q <= src_chr;
			else if (pal_sel) src_q <= src_pal;
			else src_q <= src_vram;
		end
	end

	always_comb begin
		case (src_q)
			src_vram: ppu_rdata = vram_q;
			src_pal:  ppu_rdata = pal_q;
			default:  ppu_rdata = chr_q;
		endcase
	end

endmodule

// File: design/controller_port.sv
//======================================
// Joypad port at $4016
// Strobe latch and serial shift out
//======================================
`timescale 1ns/1ps

module controller_port
	import nes_bus_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  cpu_req_t   joy_req,
	input  logic [7:0] keycode,
	output logic [7:0] joy_rdata
);

	logic       strobe;
	logic [7:0] shift_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			strobe <= 1'b0;
			shift_q <= 8'h00;
			joy_rdata <= 8'h00;
		end else begin
			// Bit 0 of any write sets the latch
			if (joy_req.wr) begin
				strobe <= joy_req.wdata[0];
			end
			// Serial bit on D0, upper bits zero
			if (joy_req.rd) begin
				joy_rdata <= {7'b0, shift_q[0]};
			end
			// Parallel load while latched, else shift on read
			if (strobe) begin
				shift_q <= keycode;
			end else if (joy_req.rd) begin
				shift_q <= {1'b1, shift_q[7:1]};
			end
		end
	end

endmodule

// File: design/cpu_bus_fabric.sv
//======================================
// CPU bus fabric
// Decodes RAM, PPU registers, joypad and PRG-ROM
//======================================
`timescale 1ns/1ps

module cpu_bus_fabric
	import nes_map_pkg::*;
	import nes_bus_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  cpu_req_t   cpu_req,
	output logic [7:0] cpu_rdata,
	input  rom_load_t  rom_load,
	output cpu_req_t   reg_req,
	input  logic [7:0] reg_rdata,
	output cpu_req_t   joy_req,
	input  logic [7:0] joy_rdata
);

	// Read source held until the next read
	typedef enum logic [2:0] {
		src_open,
		src_ram,
		src_reg,
		src_joy,
		src_prg
	} src_e;

	src_e              src_q;
	logic              ram_sel;
	logic              reg_sel;
	logic              joy_sel;
	logic              prg_sel;
	logic              prg_load;
	logic [prg_aw-1:0] prg_addr;
	logic [7:0]        ram_q;
	logic [7:0]        prg_q;

	//======================================
	// Address decode
	//======================================
	// $0000-$1FFF holds 2 KB mirrored four times
	assign ram_sel = cpu_req.addr < ppu_reg_base;
	assign reg_sel = (cpu_req.addr >= ppu_reg_base) && (cpu_req.addr <= ppu_reg_end);
	assign joy_sel = cpu_req.addr == joy_addr;
	assign prg_sel = cpu_req.addr >= prg_base;

	// Register window and joypad see only their own strobes
	always_comb begin
		reg_req = cpu_req;
		reg_req.rd = cpu_req.rd && reg_sel;
		reg_req.wr = cpu_req.wr && reg_sel;
		joy_req = cpu_req;
		joy_req.rd = cpu_req.rd && joy_sel;
		joy_req.wr = cpu_req.wr && joy_sel;
	end

	//======================================
	// Memories
	//======================================
	byte_ram #(.DEPTH(sysram_words)) sysram_i (
		.clk   (clk),
		.we    (cpu_req.wr && ram_sel),
		.re    (cpu_req.rd && ram_sel),
		.addr  (cpu_req.addr[sysram_aw-1:0]),
		.wdata (cpu_req.wdata),
		.rdata (ram_q)
	);

	// Loader owns the PRG port while it writes
	assign prg_load = rom_load.valid && (rom_load.target == tgt_prg);
	assign prg_addr = prg_load ? rom_load.addr[prg_aw-1:0] : cpu_req.addr[prg_aw-1:0];

	// CPU writes to ROM fall on the floor
	byte_ram #(.DEPTH(prg_words)) prg_rom_i (
		.clk   (clk),
		.we    (prg_load),
		.re    (cpu_req.rd && prg_sel),
		.addr  (prg_addr),
		.wdata (rom_load.data),
		.rdata (prg_q)
	);

	//======================================
	// Read data mux
	//======================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			src_q <= src_open;
		end else if (cpu_req.rd) begin
			if (ram_sel) src_q <= src_ram;
			else if (reg_sel) src_q <= src_reg;
			else if (joy_sel) src_q <= src_joy;
			else if (prg_sel) src_q <= src_prg;
			else src_q <= src_open;
		end
	end

	always_comb begin
		case (src_q)
			src_ram: cpu_rdata = ram_q;
			src_reg: cpu_rdata = reg_rdata;
			src_joy: cpu_rdata = joy_rdata;
			src_prg: cpu_rdata = prg_q;
			default: cpu_rdata = open_bus;
		endcase
	end

	// Loader and a CPU read never share the PRG port
	a_prg_port: assert property (@(posedge clk) disable iff (!rst_n)
		!(prg_load && cpu_req.rd && prg_sel));

endmodule

// File: design/cpu_axil_port.sv
//======================================
// CPU AXI4-Lite port
// Turns host transactions into CPU bus strobes
//======================================
`timescale 1ns/1ps

module cpu_axil_port
	import nes_bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	output cpu_req_t  cpu_req,
	input  logic [7:0] cpu_rdata
);

	typedef enum logic [1:0] {
		st_idle,
		st_rd_wait,
		st_resp
	} state_e;

	state_e     state_q;
	logic       rd_go;
	logic       wr_go;
	logic       bvalid_q;
	logic       rvalid_q;
	logic [7:0] rdata_q;

	//======================================
	// Accept logic
	//======================================
	// Read wins when both arrive together
	assign rd_go = (state_q == st_idle) && axil_req.arvalid;
	// Write needs address and data at once
	assign wr_go = (state_q == st_idle) && !axil_req.arvalid &&
	               axil_req.awvalid && axil_req.wvalid;

	// Ready is the accept itself, one cycle wide
	always_comb begin
		axil_rsp = '0;
		axil_rsp.arready = rd_go;
		axil_rsp.awready = wr_go;
		axil_rsp.wready = wr_go;
		axil_rsp.bvalid = bvalid_q;
		axil_rsp.bresp = axi_resp_okay;
		axil_rsp.rvalid = rvalid_q;
		// Byte lane 0 only
		axil_rsp.rdata = {24'h0, rdata_q};
		axil_rsp.rresp = axi_resp_okay;
	end

	// One bus strobe per accept
	always_comb begin
		cpu_req.rd = rd_go;
		// Lane 0 strobe clear drops the write
		cpu_req.wr = wr_go && axil_req.wstrb[0];
		cpu_req.addr = rd_go ? axil_req.araddr : axil_req.awaddr;
		cpu_req.wdata = axil_req.wdata[7:0];
	end

	//======================================
	// Transaction FSM
	//======================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= st_idle;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			case (state_q)
				st_idle: begin
					if (rd_go) begin
						state_q <= st_rd_wait;
					end else if (wr_go) begin
						// Response one cycle after the write
						state_q <= st_resp;
						bvalid_q <= 1'b1;
					end
				end
				st_rd_wait: begin
					// Fabric data is valid now
					state_q <= st_resp;
					rvalid_q <= 1'b1;
				end
				default: begin
					// Hold until the host takes it
					if (bvalid_q && axil_req.bready) begin
						bvalid_q <= 1'b0;
						state_q <= st_idle;
					end
					if (rvalid_q && axil_req.rready) begin
						rvalid_q <= 1'b0;
						state_q <= st_idle;
					end
				end
			endcase
		end
	end

	// Read byte capture
	always_ff @(posedge clk) begin
		if (state_q == st_rd_wait) begin
			rdata_q <= cpu_rdata;
		end
	end

	// One response channel at a time
	a_one_rsp: assert property (@(posedge clk) disable iff (!rst_n)
		!(bvalid_q && rvalid_q));

endmodule

// File: design/byte_ram.sv
//======================================
// Byte RAM
// Single port, registered read
//======================================
`timescale 1ns/1ps

module byte_ram #(
	parameter int DEPTH = 256
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic                     re,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic [7:0]               wdata,
	output logic [7:0]               rdata
);

	// Storage array
	logic [7:0] mem [DEPTH];

	// Write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// Read port, output holds between reads
	always_ff @(posedge clk) begin
		if (re) begin
			rdata <= mem[addr];
		end
	end

endmodule

// File: design/nes_bus_pkg.sv
//======================================
// NES bus types
// CPU, PPU, rom-load and AXI4-Lite bundles
//======================================

package nes_bus_pkg;

	// AXI response code, only OKAY is ever sent
	localparam logic [1:0] axi_resp_okay = 2'b00;

	// CPU side access, one strobe per transfer
	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [15:0] addr;
		logic [7:0]  wdata;
	} cpu_req_t;

	// PPU side access, 14-bit address space
	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [13:0] addr;
		logic [7:0]  wdata;
	} ppu_req_t;

	// Which ROM the loader fills
	typedef enum logic {
		tgt_prg = 1'b0,
		tgt_chr = 1'b1
	} rom_tgt_e;

	// Cartridge programmer port
	typedef struct packed {
		logic        valid;
		rom_tgt_e    target;
		logic [15:0] addr;
		logic [7:0]  data;
	} rom_load_t;

	//======================================
	// AXI4-Lite, host to slave and back
	//======================================
	typedef struct packed {
		logic        awvalid;
		logic [15:0] awaddr;
		logic        wvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        bready;
		logic        arvalid;
		logic [15:0] araddr;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

endpackage

// File: design/nes_map_pkg.sv
//======================================
// NES memory map
// Address windows, memory depths and the open-bus byte
//======================================

package nes_map_pkg;

	//======================================
	// Memory depths, one byte per word
	//======================================
	localparam int unsigned sysram_words = 2048;
	localparam int unsigned prg_words = 32768;
	localparam int unsigned chr_words = 8192;
	localparam int unsigned vram_words = 2048;
	localparam int unsigned pal_words = 32;

	// Matching address widths
	localparam int unsigned sysram_aw = $clog2(sysram_words);
	localparam int unsigned prg_aw = $clog2(prg_words);
	localparam int unsigned chr_aw = $clog2(chr_words);
	localparam int unsigned vram_aw = $clog2(vram_words);
	localparam int unsigned pal_aw = $clog2(pal_words);

	//======================================
	// CPU and PPU address windows
	//======================================
	// PPU registers, mirrored every 8 bytes
	localparam logic [15:0] ppu_reg_base = 16'h2000;
	localparam logic [15:0] ppu_reg_end = 16'h3FFF;
	// Joypad one
	localparam logic [15:0] joy_addr = 16'h4016;
	// Cartridge program space
	localparam logic [15:0] prg_base = 16'h8000;
	// Palette start on the PPU bus
	localparam logic [13:0] pal_base = 14'h3F00;

	// Floating data bus value
	localparam logic [7:0] open_bus = 8'hAA;

	// PPU register offsets within the window
	localparam logic [2:0] reg_ctrl = 3'd0;
	localparam logic [2:0] reg_status = 3'd2;
	localparam logic [2:0] reg_addr = 3'd6;
	localparam logic [2:0] reg_data = 3'd7;

endpackage
